// File: Bender.yml
package:
  name: rob

sources:
  - files:
      - common/rob_pkg.sv
      - rob/rob_ptr_ctrl.sv
      - rob/rob_entry_array.sv
      - hw/rob_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/rob_chk.sv
      - dv/tb_top.sv

// File: common/rob_pkg.sv
package rob_pkg;

  // buffer geometry
  localparam int ROB_SIZE   = 8;
  localparam int ROB_ADDR_W = 3;
  localparam int ROB_PTR_W  = ROB_ADDR_W + 1;

  // payload widths
  localparam int REG_ADDR_W = 5;
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int EXC_W      = 4;

  typedef logic [ROB_ADDR_W-1:0] rob_idx_t;

  // index plus wrap bit on top
  typedef logic [ROB_PTR_W-1:0] rob_ptr_t;

  typedef struct packed {
    logic                  done;
    logic                  reg_write_en;
    logic [REG_ADDR_W-1:0] reg_write_addr;
    logic                  is_delayslot;
    logic [EXC_W-1:0]      exc_type;
    logic [DATA_W-1:0]     result;
    logic [ADDR_W-1:0]     pc;
  } rob_entry_t;

  // one request word per cycle
  typedef struct packed {
    logic     write_en;
    logic     update_en;
    rob_idx_t update_addr;
    logic     read_en;
    logic     read_head_en;
    logic     commit_en;
    logic     erase_en;
    rob_idx_t erase_addr;
  } rob_ctrl_t;

  typedef struct packed {
    logic can_write;
    logic can_read;
    logic can_commit;
  } rob_status_t;

  // read port result is zero when nothing is read
  typedef struct packed {
    rob_idx_t   rob_addr;
    rob_entry_t entry;
  } rob_read_t;

endpackage

// File: dv/rob_chk.sv
module rob_chk
  import rob_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input rob_ctrl_t   ctrl,
  input rob_status_t status
);

  timeunit 1ns;
  timeprecision 100ps;

  logic fail_seen;

  initial fail_seen = 1'b0;

  write_needs_room: assert property (@(posedge clk) disable iff (!rst)
    ctrl.write_en |-> status.can_write)
  else begin
    $error("write_en asserted while can_write is low");
    fail_seen = 1'b1;
  end

  read_needs_entry: assert property (@(posedge clk) disable iff (!rst)
    ctrl.read_en |-> status.can_read)
  else begin
    $error("read_en asserted while can_read is low");
    fail_seen = 1'b1;
  end

  commit_needs_done: assert property (@(posedge clk) disable iff (!rst)
    ctrl.commit_en |-> status.can_commit)
  else begin
    $error("commit_en asserted while can_commit is low");
    fail_seen = 1'b1;
  end

  // nothing to read or commit right after reset
  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst) |-> (!status.can_read && !status.can_commit))
  else begin
    $error("can_read or can_commit set in the first cycle after reset");
    fail_seen = 1'b1;
  end

endmodule

// File: dv/rob_input.txt
// first word: line count in hex, then one cycle per line with these columns
// we ue ua re rh ce ee ea  d rw ra ds ex res pc  cw cr cc  ck  addr d rw ra ds ex res pc
21
// idle after reset
0 0 0 0 0 0 0 0  0 0 0 0 0 0 0  1 0 0  1  0 0 0 0 0 0 0 0
// allocate eight entries
1 0 0 0 0 0 0 0  0 1 1 0 0 c0 100  1 0 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 2 0 0 c1 104  1 1 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 3 1 0 c2 108  1 1 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 4 0 0 c3 10c  1 1 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 5 0 0 c4 110  1 1 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 6 0 3 c5 114  1 1 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 7 0 0 c6 118  1 1 0  1  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 1 8 0 0 c7 11c  1 1 0  1  0 0 0 0 0 0 0 0
// full, head peek
0 0 0 0 1 0 0 0  0 0 0 0 0 0 0  0 1 0  1  0 0 1 1 0 0 c0 100
// issue reads in order, the second one also asks for the head
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  0 0 1 1 0 0 c0 100
0 0 0 1 1 0 0 0  0 0 0 0 0 0 0  0 1 0  1  1 0 1 2 0 0 c1 104
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  2 0 1 3 1 0 c2 108
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  3 0 1 4 0 0 c3 10c
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  4 0 1 5 0 0 c4 110
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  5 0 1 6 0 3 c5 114
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  6 0 1 7 0 0 c6 118
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  7 0 1 8 0 0 c7 11c
// read pointer at tail, head still at 0
0 0 0 0 1 0 0 0  0 0 0 0 0 0 0  0 0 0  1  0 0 1 1 0 0 c0 100
// complete a younger entry
0 1 2 0 0 0 0 0  1 1 3 1 0 d2 108  0 0 0  1  0 0 0 0 0 0 0 0
// complete the head, the peek still sees the old line
0 1 0 0 1 0 0 0  1 1 1 0 0 d0 100  0 0 0  1  0 0 1 1 0 0 c0 100
0 0 0 0 1 0 0 0  0 0 0 0 0 0 0  0 0 1  1  0 1 1 1 0 0 d0 100
0 0 0 0 0 1 0 0  0 0 0 0 0 0 0  0 0 1  1  0 0 0 0 0 0 0 0
0 0 0 0 1 0 0 0  0 0 0 0 0 0 0  1 0 0  1  1 0 1 2 0 0 c1 104
// write and update together, only the write lands
1 1 2 0 0 0 0 0  0 1 9 0 0 c8 120  1 0 0  1  0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  0 1 0  1  0 0 1 9 0 0 c8 120
0 1 1 0 0 0 0 0  1 1 2 0 0 d1 104  0 0 0  1  0 0 0 0 0 0 0 0
0 0 0 0 0 1 0 0  0 0 0 0 0 0 0  0 0 1  1  0 0 0 0 0 0 0 0
// erase from 5 with a dropped write and a commit
1 0 0 0 0 1 1 5  1 1 1f 1 f ee 1fc  1 0 1  1  0 0 0 0 0 0 0 0
0 0 0 0 1 0 0 0  0 0 0 0 0 0 0  1 0 0  1  3 0 1 4 0 0 c3 10c
// next allocation lands at 5
1 0 0 0 0 0 0 0  0 1 a 0 0 c9 124  1 0 0  1  0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0  0 0 0 0 0 0 0  1 1 0  1  5 0 1 a 0 0 c9 124
0 0 0 0 0 0 0 0  0 0 0 0 0 0 0  1 0 0  1  0 0 0 0 0 0 0 0

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release lands 2 ns after an edge
  initial begin
    rst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b1;
  end

endmodule

// File: dv/tb_top.sv
module tb_top
  import rob_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // tokens per line in the data file
  localparam int FIELDS      = 27;
  localparam int MAX_LINES   = 40;
  localparam int RST_TIMEOUT = 50;

  logic        clk;
  logic        rst;
  rob_ctrl_t   ctrl;
  rob_entry_t  entry_in;
  rob_status_t status;
  rob_read_t   rd;

  // word 0 holds the line count and FIELDS words per line follow
  logic [31:0] vec_mem [0:FIELDS*MAX_LINES];

  tb_clk_gen tb_clk_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  rob_top rob_top_inst (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .entry_in (entry_in),
    .status   (status),
    .rd       (rd)
  );

  bind rob_top rob_chk rob_chk_inst (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .status (status)
  );

  function automatic rob_ctrl_t ctrl_at(input int base);
    rob_ctrl_t c;
    c.write_en     = vec_mem[base][0];
    c.update_en    = vec_mem[base+1][0];
    c.update_addr  = vec_mem[base+2][ROB_ADDR_W-1:0];
    c.read_en      = vec_mem[base+3][0];
    c.read_head_en = vec_mem[base+4][0];
    c.commit_en    = vec_mem[base+5][0];
    c.erase_en     = vec_mem[base+6][0];
    c.erase_addr   = vec_mem[base+7][ROB_ADDR_W-1:0];
    return c;
  endfunction

  function automatic rob_entry_t entry_at(input int base);
    rob_entry_t e;
    e.done           = vec_mem[base][0];
    e.reg_write_en   = vec_mem[base+1][0];
    e.reg_write_addr = vec_mem[base+2][REG_ADDR_W-1:0];
    e.is_delayslot   = vec_mem[base+3][0];
    e.exc_type       = vec_mem[base+4][EXC_W-1:0];
    e.result         = vec_mem[base+5][DATA_W-1:0];
    e.pc             = vec_mem[base+6][ADDR_W-1:0];
    return e;
  endfunction

  function automatic rob_status_t status_at(input int base);
    rob_status_t s;
    s.can_write  = vec_mem[base][0];
    s.can_read   = vec_mem[base+1][0];
    s.can_commit = vec_mem[base+2][0];
    return s;
  endfunction

  function automatic rob_read_t read_at(input int base);
    rob_read_t r;
    r.rob_addr = vec_mem[base][ROB_ADDR_W-1:0];
    r.entry    = entry_at(base + 1);
    return r;
  endfunction

  task automatic fail_now();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_status(input rob_status_t got, input rob_status_t exp,
                              input int line_no);
    if (got !== exp) begin
      $display("MISMATCH line %0d status got %h expected %h", line_no, got, exp);
      fail_now();
    end
  endtask

  task automatic check_read(input rob_read_t got, input rob_read_t exp,
                            input int line_no);
    if (got !== exp) begin
      $display("MISMATCH line %0d rd got %h expected %h", line_no, got, exp);
      fail_now();
    end
  endtask

  initial begin
    int n_lines;
    int line_no;
    int wait_cnt;
    int base;
    ctrl     = '0;
    entry_in = '0;
    $readmemh("dv/rob_input.txt", vec_mem);
    n_lines = int'(vec_mem[0]);
    if (n_lines < 1 || n_lines > MAX_LINES) begin
      $display("data file line count %0d is out of range", n_lines);
      fail_now();
    end

    wait_cnt = 0;
    while (rst !== 1'b1) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > RST_TIMEOUT) begin
        $display("reset was never released");
        fail_now();
      end
    end

    // one line per cycle is driven after the edge and checked before the next
    line_no  = 0;
    wait_cnt = 0;
    while (line_no < n_lines) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > MAX_LINES) begin
        $display("end of the data file was never reached");
        fail_now();
      end
      #2;
      base     = 1 + line_no * FIELDS;
      ctrl     = ctrl_at(base);
      entry_in = entry_at(base + 8);
      #16;
      check_status(status, status_at(base + 15), line_no);
      if (vec_mem[base+18][0]) begin
        check_read(rd, read_at(base + 19), line_no);
      end
      if (rob_top_inst.rob_chk_inst.fail_seen) begin
        $display("protocol assertion failed at line %0d", line_no);
        fail_now();
      end
      line_no++;
    end

    @(posedge clk);
    #2;
    ctrl     = '0;
    entry_in = '0;
    @(posedge clk);
    #2;
    if (rob_top_inst.rob_chk_inst.fail_seen) begin
      $display("protocol assertion failed after the last line");
      fail_now();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: hw/rob_top.sv
module rob_top
  import rob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  rob_ctrl_t   ctrl,
  input  rob_entry_t  entry_in,
  output rob_status_t status,
  output rob_read_t   rd
);

  logic     line_we;
  rob_idx_t line_idx;
  logic     rd_valid;
  rob_idx_t rd_idx;
  rob_idx_t head_idx;
  logic     head_done;

  rob_ptr_ctrl rob_ptr_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .head_done (head_done),
    .status    (status),
    .line_we   (line_we),
    .line_idx  (line_idx),
    .rd_valid  (rd_valid),
    .rd_idx    (rd_idx),
    .head_idx  (head_idx)
  );

  rob_entry_array rob_entry_array_inst (
    .clk       (clk),
    .rst       (rst),
    .line_we   (line_we),
    .line_idx  (line_idx),
    .entry_in  (entry_in),
    .rd_valid  (rd_valid),
    .rd_idx    (rd_idx),
    .head_idx  (head_idx),
    .head_done (head_done),
    .rd        (rd)
  );

endmodule

// File: project.f
common/rob_pkg.sv
rob/rob_ptr_ctrl.sv
rob/rob_entry_array.sv
hw/rob_top.sv
dv/tb_clk_gen.sv
dv/rob_chk.sv
dv/tb_top.sv

// File: rob/rob_entry_array.sv
module rob_entry_array
  import rob_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       line_we,
  input  rob_idx_t   line_idx,
  input  rob_entry_t entry_in,
  input  logic       rd_valid,
  input  rob_idx_t   rd_idx,
  input  rob_idx_t   head_idx,
  output logic       head_done,
  output rob_read_t  rd
);

  // payload storage
  rob_entry_t lines [ROB_SIZE];

  // done bits cleared on reset
  logic [ROB_SIZE-1:0] done_q;

  rob_entry_t sel_entry;

  always_ff @(posedge clk) begin
    if (!rst) begin
      done_q <= '0;
    end else if (line_we) begin
      done_q[line_idx] <= entry_in.done;
    end
  end

  always_ff @(posedge clk) begin
    if (line_we) begin
      lines[line_idx] <= entry_in;
    end
  end

  // done comes from the reset-cleared copy
  always_comb begin
    sel_entry      = lines[rd_idx];
    sel_entry.done = done_q[rd_idx];
  end

  always_comb begin
    if (rd_valid) begin
      rd.rob_addr = rd_idx;
      rd.entry    = sel_entry;
    end else begin
      rd = '0;
    end
  end

  assign head_done = done_q[head_idx];

endmodule

// File: rob/rob_ptr_ctrl.sv
module rob_ptr_ctrl
  import rob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  rob_ctrl_t   ctrl,
  input  logic        head_done,
  output rob_status_t status,
  output logic        line_we,
  output rob_idx_t    line_idx,
  output logic        rd_valid,
  output rob_idx_t    rd_idx,
  output rob_idx_t    head_idx
);

  rob_ptr_t head_ptr;
  rob_ptr_t read_ptr;
  rob_ptr_t tail_ptr;

  rob_idx_t head_i;
  rob_idx_t read_i;
  rob_idx_t tail_i;

  logic empty;
  logic full;
  logic alloc;

  // erase helpers
  rob_idx_t erase_dist;
  rob_ptr_t erase_tail;
  rob_ptr_t read_adv;
  rob_ptr_t read_span;
  logic     read_past_tail;

  assign head_i = head_ptr[ROB_ADDR_W-1:0];
  assign read_i = read_ptr[ROB_ADDR_W-1:0];
  assign tail_i = tail_ptr[ROB_ADDR_W-1:0];

  // wrap bit tells empty from full when the indices match
  assign empty = (head_ptr == tail_ptr);
  assign full  = (head_i == tail_i) &&
                 (head_ptr[ROB_ADDR_W] != tail_ptr[ROB_ADDR_W]);

  always_comb begin
    status.can_write  = !full;
    status.can_read   = (read_ptr != tail_ptr);
    status.can_commit = !empty && head_done;
  end

  // allocation is dropped while an erase is in flight
  assign alloc = ctrl.write_en && !ctrl.erase_en;

  // write wins over update on the shared entry bus
  always_comb begin
    line_we  = alloc || ctrl.update_en;
    line_idx = alloc ? tail_i : ctrl.update_addr;
  end

  // issue read wins over head peek
  always_comb begin
    rd_valid = ctrl.read_en || ctrl.read_head_en;
    rd_idx   = ctrl.read_en ? read_i : head_i;
  end

  assign head_idx = head_i;

  // new tail keeps the wrap bit by counting from the head
  assign erase_dist = ctrl.erase_addr - head_i;
  assign erase_tail = head_ptr + {1'b0, erase_dist};

  assign read_adv  = ctrl.read_en ? read_ptr + rob_ptr_t'(1) : read_ptr;
  assign read_span = read_adv - head_ptr;

  // read pointer further from head than the new tail
  assign read_past_tail = read_span > {1'b0, erase_dist};

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_ptr <= '0;
    end else if (ctrl.commit_en) begin
      head_ptr <= head_ptr + rob_ptr_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      read_ptr <= '0;
    end else if (ctrl.erase_en && read_past_tail) begin
      read_ptr <= erase_tail;
    end else begin
      read_ptr <= read_adv;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      tail_ptr <= '0;
    end else if (ctrl.erase_en) begin
      tail_ptr <= erase_tail;
    end else if (ctrl.write_en) begin
      tail_ptr <= tail_ptr + rob_ptr_t'(1);
    end
  end

endmodule
